//--- Bender.yml
package:
  name: pipe_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/fetchStage.sv
      - hdl/regFile.sv
      - hdl/decodeStage.sv
      - hdl/executeStage.sv
      - hdl/memoryStage.sv
      - hdl/hazardUnit.sv
      - hdl/pipeCore.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/pipeCore_assert.sv
      - bench/pipeCore_tb.sv

//--- bench/pipeCore_assert.sv
`include "core_defines.svh"

module pipeCore_assert (
  input logic                 clk,
  input logic                 arstN,
  input logic [`CORE_PCW-1:0] pcF,
  input core_pkg::memToWbS    retire,
  input core_pkg::hazardCtrlS hz,
  input logic                 branchTaken
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned failCount = 0;  // Failed assertions so far

  // A fetch stall freezes the PC for the next edge
  pcHoldsOnStall: assert property (@(posedge clk) disable iff (!arstN)
    hz.stallF |=> $stable(pcF))
    else begin
      $error("pcF moved while stallF was high");
      failCount++;
    end

  resetQuietRetire: assert property (@(posedge clk) !arstN |=> !retire.valid)
    else begin
      $error("retire.valid high during reset");
      failCount++;
    end

  // First word needs four edges to reach writeback
  startupQuietRetire: assert property (@(posedge clk) $rose(arstN) |-> !retire.valid [*4])
    else begin
      $error("retire.valid high within four cycles of reset release");
      failCount++;
    end

  noStallOnRedirect: assert property (@(posedge clk) disable iff (!arstN)
    !(hz.stallD && branchTaken))
    else begin
      $error("stallD raised together with a branch redirect");
      failCount++;
    end

  forwardSelectLegal: assert property (@(posedge clk) disable iff (!arstN)
    (hz.forwardA != 2'd3) && (hz.forwardB != 2'd3) && (hz.forwardC != 2'd3))
    else begin
      $error("Forward select with the unused code 3");
      failCount++;
    end

endmodule

//--- bench/pipeCore_tb.sv
`include "core_defines.svh"

module pipeCore_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_SEED  = 47741;
  localparam int PROG_DEPTH = 32;  // Program words per test
  localparam int N_TESTS    = 5;
  localparam int DRAIN      = 8;   // Quiet cycles watched after the last expected write
  // Reset, the worst case run of a full program, the drain and some slack
  localparam int TEST_CYCLES     = 3 + 2 * PROG_DEPTH + 16 + DRAIN + 20;
  localparam int WATCHDOG_CYCLES = N_TESTS * TEST_CYCLES;

  logic                  clk;
  logic                  arstN;
  logic [`CORE_PCW-1:0]  pcF;
  core_pkg::instrU       instrF;
  core_pkg::memToWbS     retire;
  core_pkg::instrU       progMem [PROG_DEPTH];
  int                    progLen;
  logic [`CORE_REGW-1:0] expRd [$];   // Register writes in program order
  logic [`CORE_XLEN-1:0] expVal [$];

  pipeCore pipeCore_i (
    .clk    (clk),
    .arstN  (arstN),
    .pcF    (pcF),
    .instrF (instrF),
    .retire (retire)
  );

  bind pipeCore pipeCore_assert assertChecks (
    .clk         (clk),
    .arstN       (arstN),
    .pcF         (pcF),
    .retire      (retire),
    .hz          (hz),
    .branchTaken (branchTaken)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Instruction memory answers in the same cycle and returns NOP past the program
  assign instrF = (pcF < PROG_DEPTH) ? progMem[pcF] : '0;

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic valueMismatch(input string testName, input string sig,
                               input logic [31:0] expected, input logic [31:0] got);
    reportFailure($sformatf("ERROR time=%0t %s %s expected 0x%08h got 0x%08h",
                            $time, testName, sig, expected, got));
  endtask

  function automatic logic [15:0] randImm();
    return 16'($urandom);
  endfunction

  function automatic logic [15:0] randAddr();
    return 16'($urandom % 200);  // Leaves room for small offsets below the RAM top
  endfunction

  task automatic clearProgram();
    foreach (progMem[i]) begin
      progMem[i] = '0;  // All zero word is a NOP
    end
    progLen = 0;
  endtask

  task automatic dpInstr(input core_pkg::opcodeE op, input int rd, input int rn,
                         input int rm, input int ra, input logic [15:0] imm);
    core_pkg::instrU w;
    w.dp.opcode = op;
    w.dp.rd     = `CORE_REGW'(rd);
    w.dp.rn     = `CORE_REGW'(rn);
    w.dp.rm     = `CORE_REGW'(rm);
    w.dp.ra     = `CORE_REGW'(ra);
    w.dp.imm    = imm;
    progMem[progLen] = w;
    progLen++;
  endtask

  task automatic bzInstr(input int rn, input int offset);
    core_pkg::instrU w;
    w.br.opcode = core_pkg::opBz;
    w.br.rn     = `CORE_REGW'(rn);
    w.br.offset = 25'(offset);  // Words counted from the BZ itself
    progMem[progLen] = w;
    progLen++;
  endtask

  // Sequential ISA model that runs one instruction at a time from zeroed registers and memory
  task automatic runModel(output int steps);
    logic [`CORE_XLEN-1:0] regs [`CORE_NREG];
    logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_DEPTH];
    core_pkg::instrU       w;
    logic [`CORE_XLEN-1:0] opA;
    logic [`CORE_XLEN-1:0] opB;
    logic [`CORE_XLEN-1:0] opC;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] res;
    logic                  writes;
    int                    pc;
    expRd.delete();
    expVal.delete();
    foreach (regs[i]) regs[i] = '0;
    foreach (dmem[i]) dmem[i] = '0;
    pc    = 0;
    steps = 0;
    while (pc >= 0 && pc < progLen && steps < 4 * PROG_DEPTH) begin
      w      = progMem[pc];
      opA    = regs[w.dp.rn];
      opB    = regs[w.dp.rm];
      opC    = regs[w.dp.ra];
      imm    = {{16{w.dp.imm[15]}}, w.dp.imm};
      res    = '0;
      writes = 1'b1;
      steps++;
      pc++;
      case (w.dp.opcode)
        core_pkg::opAdd:  res = opA + opB;
        core_pkg::opSub:  res = opA - opB;
        core_pkg::opAddi: res = opA + imm;
        core_pkg::opMla:  res = opA * opB + opC;  // Low 32 bits of the product
        core_pkg::opLdr:  res = dmem[(opA + imm) % `CORE_DMEM_DEPTH];
        core_pkg::opStr: begin
          dmem[(opA + imm) % `CORE_DMEM_DEPTH] = opB;
          writes = 1'b0;
        end
        core_pkg::opBz: begin
          if (regs[w.br.rn] == '0) pc = pc - 1 + int'($signed(w.br.offset));
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes) begin
        regs[w.dp.rd] = res;
        expRd.push_back(w.dp.rd);
        expVal.push_back(res);
      end
    end
  endtask

  // Reset stays low for two cycles while the program is loaded
  task automatic startTest();
    @(posedge clk);
    arstN <= 1'b0;
    @(negedge clk);
    clearProgram();
  endtask

  task automatic runProgram(input string testName);
    int steps;
    int idx;
    int cycles;
    int bound;
    runModel(steps);
    bound = 2 * steps + 16;  // Room for a stall or two bubbles behind every instruction
    repeat (2) @(posedge clk);
    assert (pcF == '0)
      else valueMismatch(testName, "pcF", '0, pcF);
    arstN  <= 1'b1;
    idx    = 0;
    cycles = 0;
    while (idx < expRd.size() && cycles < bound) begin
      @(negedge clk);  // Retire record is stable in the middle of the cycle
      cycles++;
      if (retire.valid && retire.regWrite) begin
        assert (retire.rd == expRd[idx])
          else valueMismatch(testName, "retire.rd", expRd[idx], retire.rd);
        assert (retire.value == expVal[idx])
          else valueMismatch(testName, "retire.value", expVal[idx], retire.value);
        idx++;
      end
    end
    assert (idx == expRd.size())
      else reportFailure($sformatf("%s retired only %0d of %0d register writes in %0d cycles",
                                   testName, idx, expRd.size(), bound));
    repeat (DRAIN) begin
      @(negedge clk);
      assert (!(retire.valid && retire.regWrite))
        else reportFailure($sformatf("%s retired an unexpected write to r%0d",
                                     testName, retire.rd));
    end
    $display("%s: %0d register writes matched", testName, idx);
  endtask

  task automatic testIndependent();
    startTest();
    dpInstr(core_pkg::opAddi, 1, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 2, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 3, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 4, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 5, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAdd, 6, 1, 2, 0, '0);  // Sources four and more words back
    dpInstr(core_pkg::opSub, 7, 3, 4, 0, '0);  // r4 comes through register write-through
    runProgram("independent");
  endtask

  task automatic testForwarding();
    startTest();
    dpInstr(core_pkg::opAddi, 1, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAdd, 2, 1, 1, 0, '0);   // Both operands from the memory stage
    dpInstr(core_pkg::opSub, 3, 2, 1, 0, '0);   // Memory stage and writeback
    dpInstr(core_pkg::opMla, 4, 3, 2, 1, '0);   // Memory, writeback and register file
    dpInstr(core_pkg::opMla, 5, 4, 4, 3, '0);
    dpInstr(core_pkg::opAddi, 6, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 6, 6, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 6, 6, 0, 0, randImm());
    dpInstr(core_pkg::opAdd, 7, 6, 5, 0, '0);   // Youngest r6 wins over the one in writeback
    runProgram("forwarding");
  endtask

  task automatic testLoadUse();
    startTest();
    dpInstr(core_pkg::opAddi, 1, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 2, 0, 0, 0, randAddr());
    dpInstr(core_pkg::opStr, 0, 2, 1, 0, 16'd4);
    dpInstr(core_pkg::opLdr, 3, 2, 0, 0, 16'd4);
    dpInstr(core_pkg::opAdd, 4, 3, 1, 0, '0);   // Load result on rn
    dpInstr(core_pkg::opLdr, 5, 2, 0, 0, 16'd4);
    dpInstr(core_pkg::opMla, 6, 1, 1, 5, '0);   // Load result as the accumulator
    dpInstr(core_pkg::opLdr, 7, 2, 0, 0, 16'd4);
    dpInstr(core_pkg::opAdd, 7, 7, 7, 0, '0);   // Load result on rn and rm at once
    runProgram("load-use");
  endtask

  task automatic testBranch();
    startTest();
    dpInstr(core_pkg::opAddi, 1, 0, 0, 0, randImm() | 16'd1);
    bzInstr(0, 3);                                     // Taken on r0 and lands three words on
    dpInstr(core_pkg::opAddi, 2, 0, 0, 0, randImm());  // Skipped
    dpInstr(core_pkg::opAddi, 3, 0, 0, 0, randImm());  // Skipped
    dpInstr(core_pkg::opAddi, 4, 0, 0, 0, randImm() | 16'd1);  // Odd so never zero
    bzInstr(4, 5);                                     // Falls through
    dpInstr(core_pkg::opSub, 1, 1, 1, 0, '0);          // Stale r1 in the register file is odd
    bzInstr(1, 3);                                     // Zero test on a forwarded rn
    dpInstr(core_pkg::opAddi, 6, 0, 0, 0, randImm());  // Skipped
    dpInstr(core_pkg::opStr, 0, 0, 4, 0, '0);          // Skipped store must not land
    dpInstr(core_pkg::opLdr, 7, 0, 0, 0, '0);
    dpInstr(core_pkg::opAdd, 6, 7, 4, 0, '0);
    runProgram("branch");
  endtask

  task automatic testStoreLoad();
    startTest();
    dpInstr(core_pkg::opAddi, 1, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 2, 0, 0, 0, randImm());
    dpInstr(core_pkg::opAddi, 3, 0, 0, 0, randAddr());
    dpInstr(core_pkg::opStr, 0, 3, 1, 0, 16'd0);
    dpInstr(core_pkg::opStr, 0, 3, 2, 0, 16'd1);
    dpInstr(core_pkg::opLdr, 4, 3, 0, 0, 16'd0);   // Other address written in between
    dpInstr(core_pkg::opLdr, 5, 3, 0, 0, 16'd1);
    dpInstr(core_pkg::opAddi, 6, 4, 0, 0, randImm());
    dpInstr(core_pkg::opStr, 0, 3, 6, 0, 16'd2);   // Store data from the memory stage
    dpInstr(core_pkg::opLdr, 7, 3, 0, 0, 16'd2);   // Same address right behind the store
    dpInstr(core_pkg::opStr, 0, 3, 7, 0, 16'd5);   // Store data straight from a load
    dpInstr(core_pkg::opLdr, 1, 3, 0, 0, 16'd5);
    runProgram("store-load");
  endtask

  // A failed bound assertion ends the run at the next falling edge
  always @(negedge clk) begin
    if (pipeCore_i.assertChecks.failCount != 0) begin
      reportFailure("A bound assertion failed, its message is printed above");
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    reportFailure($sformatf("Timeout after %0d cycles, the tests did not finish",
                            WATCHDOG_CYCLES));
  end

  initial begin : testSequence
    clk   = 1'b0;
    arstN = 1'b0;
    clearProgram();
    void'($urandom(RAND_SEED));
    testIndependent();
    testForwarding();
    testLoadUse();
    testBranch();
    testStoreLoad();
    if (pipeCore_i.assertChecks.failCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      reportFailure("Bound assertions failed during the run");
    end
  end

endmodule

//--- build.f
+incdir+hdl
hdl/core_pkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/pipeCore.sv
bench/pipeCore_assert.sv
bench/pipeCore_tb.sv

//--- hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Width of a data word and of an instruction word
`define CORE_XLEN 32

// Architectural register file
`define CORE_NREG 8   // Number of general registers
`define CORE_REGW 3   // Bits of a register index

// The PC counts words, not bytes
`define CORE_PCW 16

// Data RAM inside the memory stage
`define CORE_DMEM_DEPTH 256  // Words of data memory
`define CORE_DMEM_AW 8       // Low result bits that address the data RAM

`endif

//--- hdl/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  // Opcode sits in the top nibble of every instruction word
  typedef enum logic [3:0] {
    opNop  = 4'd0,
    opAdd  = 4'd1,  // rd = rn + rm
    opSub  = 4'd2,  // rd = rn - rm
    opAddi = 4'd3,  // rd = rn + imm
    opMla  = 4'd4,  // rd = rn * rm + ra
    opLdr  = 4'd5,  // rd = mem[rn + imm]
    opStr  = 4'd6,  // mem[rn + imm] = rm
    opBz   = 4'd7   // pc = pc + offset when rn is zero
  } opcodeE;

  // Register format used by every instruction except BZ
  typedef struct packed {
    opcodeE                opcode;
    logic [`CORE_REGW-1:0] rd;
    logic [`CORE_REGW-1:0] rn;
    logic [`CORE_REGW-1:0] rm;
    logic [`CORE_REGW-1:0] ra;
    logic signed [15:0]    imm;
  } dpFormatS;

  // Branch format, rn moves up to make room for a wide word offset
  typedef struct packed {
    opcodeE                opcode;
    logic [`CORE_REGW-1:0] rn;
    logic signed [24:0]    offset;
  } brFormatS;

  typedef union packed {
    dpFormatS dp;
    brFormatS br;
  } instrU;

  typedef struct packed {
    logic                 valid;
    logic [`CORE_PCW-1:0] pc;
    instrU                instr;
  } fetchToDecS;

  typedef struct packed {
    logic                  valid;
    opcodeE                opcode;
    logic [`CORE_REGW-1:0] rd;
    logic [`CORE_REGW-1:0] rn;   // Index behind opA
    logic [`CORE_REGW-1:0] rm;   // Index behind opB
    logic [`CORE_REGW-1:0] ra;   // Index behind opC
    logic [`CORE_XLEN-1:0] opA;
    logic [`CORE_XLEN-1:0] opB;
    logic [`CORE_XLEN-1:0] opC;
    logic [`CORE_XLEN-1:0] imm;  // Sign extended immediate or branch offset
    logic [`CORE_PCW-1:0]  pc;
    logic                  regWrite;
    logic                  memToReg;
    logic                  memWrite;
  } decToExeS;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_REGW-1:0] rd;
    logic [`CORE_XLEN-1:0] result;     // ALU value or data address
    logic [`CORE_XLEN-1:0] storeData;
    logic                  regWrite;
    logic                  memToReg;
    logic                  memWrite;
  } exeToMemS;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_REGW-1:0] rd;
    logic [`CORE_XLEN-1:0] value;
    logic                  regWrite;
  } memToWbS;

  // Source registers of the decoding instruction, bit 0 of useMask is rn, bit 2 is ra
  typedef struct packed {
    logic [`CORE_REGW-1:0] rn;
    logic [`CORE_REGW-1:0] rm;
    logic [`CORE_REGW-1:0] ra;
    logic [2:0]            useMask;
  } decRegsS;

  // Forward select is 2 for memory stage, 1 for writeback, 0 for register file
  typedef struct packed {
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic [1:0] forwardC;
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;
  } hazardCtrlS;

endpackage

//--- hdl/decodeStage.sv
`include "core_defines.svh"

module decodeStage (
  input  logic                  clk,
  input  logic                  arstN,
  input  core_pkg::hazardCtrlS  hz,
  input  core_pkg::fetchToDecS  fromFetch,
  output logic [`CORE_REGW-1:0] regAddrA,
  output logic [`CORE_REGW-1:0] regAddrB,
  output logic [`CORE_REGW-1:0] regAddrC,
  input  logic [`CORE_XLEN-1:0] regDataA,
  input  logic [`CORE_XLEN-1:0] regDataB,
  input  logic [`CORE_XLEN-1:0] regDataC,
  output core_pkg::decRegsS     decRegs,
  output core_pkg::decToExeS    toExe
);

  core_pkg::opcodeE      opcode;
  logic                  isBranch;
  logic                  regWrite;
  logic                  memToReg;
  logic                  memWrite;
  logic [2:0]            useMask;
  logic [`CORE_XLEN-1:0] immExt;

  assign opcode   = fromFetch.instr.dp.opcode;  // Opcode field is shared by both views
  assign isBranch = (opcode == core_pkg::opBz);

  // BZ keeps rn in the rd slot, everything else uses the register format
  assign regAddrA = isBranch ? fromFetch.instr.br.rn : fromFetch.instr.dp.rn;
  assign regAddrB = fromFetch.instr.dp.rm;  // Second ALU operand and STR data
  assign regAddrC = fromFetch.instr.dp.ra;  // Accumulator of MLA
  assign immExt   = isBranch ? `CORE_XLEN'($signed(fromFetch.instr.br.offset))
                             : `CORE_XLEN'($signed(fromFetch.instr.dp.imm));

  // Control bits and the set of registers the instruction really reads
  always_comb begin
    regWrite = 1'b0;
    memToReg = 1'b0;
    memWrite = 1'b0;
    useMask  = 3'b000;
    case (opcode)
      core_pkg::opAdd, core_pkg::opSub: begin
        regWrite = 1'b1;
        useMask  = 3'b011;
      end
      core_pkg::opAddi: begin
        regWrite = 1'b1;
        useMask  = 3'b001;
      end
      core_pkg::opMla: begin
        regWrite = 1'b1;
        useMask  = 3'b111;  // All three read ports busy
      end
      core_pkg::opLdr: begin
        regWrite = 1'b1;
        memToReg = 1'b1;
        useMask  = 3'b001;
      end
      core_pkg::opStr: begin
        memWrite = 1'b1;
        useMask  = 3'b011;  // Address base and store data
      end
      core_pkg::opBz:  useMask = 3'b001;
      default:         useMask = 3'b000;  // NOP and unused codes do nothing
    endcase
  end

  // A bubble in the fetch register reads nothing and writes nothing
  assign decRegs.rn      = regAddrA;
  assign decRegs.rm      = regAddrB;
  assign decRegs.ra      = regAddrC;
  assign decRegs.useMask = fromFetch.valid ? useMask : 3'b000;

  // Decode to execute register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toExe <= '0;
    end else if (hz.flushE) begin
      toExe <= '0;  // Bubble for a load-use stall or a taken branch
    end else if (!hz.stallD) begin
      toExe.valid    <= fromFetch.valid;
      toExe.opcode   <= opcode;
      toExe.rd       <= fromFetch.instr.dp.rd;
      toExe.rn       <= regAddrA;
      toExe.rm       <= regAddrB;
      toExe.ra       <= regAddrC;
      toExe.opA      <= regDataA;
      toExe.opB      <= regDataB;
      toExe.opC      <= regDataC;
      toExe.imm      <= immExt;
      toExe.pc       <= fromFetch.pc;
      toExe.regWrite <= fromFetch.valid && regWrite;
      toExe.memToReg <= fromFetch.valid && memToReg;
      toExe.memWrite <= fromFetch.valid && memWrite;
    end
  end

endmodule

//--- hdl/executeStage.sv
`include "core_defines.svh"

module executeStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  core_pkg::hazardCtrlS hz,
  input  core_pkg::decToExeS   fromDec,
  input  core_pkg::exeToMemS   memFwd,
  input  core_pkg::memToWbS    wbFwd,
  output logic                 branchTaken,
  output logic [`CORE_PCW-1:0] branchTarget,
  output core_pkg::exeToMemS   toMem
);

  logic [`CORE_XLEN-1:0] opA;
  logic [`CORE_XLEN-1:0] opB;
  logic [`CORE_XLEN-1:0] opC;
  logic [`CORE_XLEN-1:0] result;

  // Operand source picked by the hazard unit
  function automatic logic [`CORE_XLEN-1:0] fwdMux(
    input logic [1:0]            sel,
    input logic [`CORE_XLEN-1:0] regVal,
    input logic [`CORE_XLEN-1:0] memVal,
    input logic [`CORE_XLEN-1:0] wbVal
  );
    case (sel)
      2'd2:    return memVal;  // Result one instruction ahead
      2'd1:    return wbVal;   // Result two instructions ahead
      default: return regVal;  // Value read in decode
    endcase
  endfunction

  assign opA = fwdMux(hz.forwardA, fromDec.opA, memFwd.result, wbFwd.value);
  assign opB = fwdMux(hz.forwardB, fromDec.opB, memFwd.result, wbFwd.value);
  assign opC = fwdMux(hz.forwardC, fromDec.opC, memFwd.result, wbFwd.value);

  always_comb begin
    case (fromDec.opcode)
      core_pkg::opAdd:                  result = opA + opB;
      core_pkg::opSub:                  result = opA - opB;
      core_pkg::opMla:                  result = opA * opB + opC;  // Low word of the product
      core_pkg::opAddi, core_pkg::opLdr,
      core_pkg::opStr:                  result = opA + fromDec.imm;  // Also the data address
      default:                          result = '0;
    endcase
  end

  // BZ resolves here against the forwarded rn, offset counts words from the BZ itself
  assign branchTaken  = fromDec.valid && (fromDec.opcode == core_pkg::opBz) && (opA == '0);
  assign branchTarget = fromDec.pc + fromDec.imm[`CORE_PCW-1:0];

  // Execute to memory register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toMem <= '0;
    end else begin
      toMem.valid     <= fromDec.valid;
      toMem.rd        <= fromDec.rd;
      toMem.result    <= result;
      toMem.storeData <= opB;  // rm after forwarding
      toMem.regWrite  <= fromDec.regWrite;
      toMem.memToReg  <= fromDec.memToReg;
      toMem.memWrite  <= fromDec.memWrite;
    end
  end

endmodule

//--- hdl/fetchStage.sv
`include "core_defines.svh"

module fetchStage (
  input  logic                 clk,
  input  logic                 arstN,
  input  core_pkg::hazardCtrlS hz,
  input  logic                 branchTaken,
  input  logic [`CORE_PCW-1:0] branchTarget,
  input  core_pkg::instrU      instrF,
  output logic [`CORE_PCW-1:0] pcF,
  output core_pkg::fetchToDecS toDec
);

  // Program counter, a redirect from execute beats a load-use stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= '0;
    end else if (branchTaken) begin
      pcF <= branchTarget;  // Jump lands on the next edge
    end else if (!hz.stallF) begin
      pcF <= pcF + 1'b1;    // One word per cycle
    end
  end

  // Fetch to decode register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toDec <= '0;
    end else if (hz.flushD) begin
      toDec <= '0;  // Word fetched behind a taken branch is dropped
    end else if (!hz.stallD) begin
      toDec.valid <= 1'b1;
      toDec.pc    <= pcF;
      toDec.instr <= instrF;  // Instruction memory answers in the same cycle
    end
    // With stallD high the decoding word stays in place
  end

endmodule

//--- hdl/hazardUnit.sv
`include "core_defines.svh"

module hazardUnit (
  input  core_pkg::decRegsS    decRegs,
  input  core_pkg::decToExeS   exeInfo,
  input  logic                 branchTaken,
  input  core_pkg::exeToMemS   memInfo,
  input  core_pkg::memToWbS    wbInfo,
  output core_pkg::hazardCtrlS hz
);

  logic [`CORE_REGW-1:0] exeSrc [3];  // rn, rm and ra of the executing instruction
  logic [2:0]            matchM;      // Source matches the memory stage destination
  logic [2:0]            matchW;      // Source matches the writeback destination
  logic [1:0]            fwdSel [3];
  logic [2:0]            matchD;      // Decode source matches the execute destination
  logic                  ldrStall;

  assign exeSrc[0] = exeInfo.rn;
  assign exeSrc[1] = exeInfo.rm;
  assign exeSrc[2] = exeInfo.ra;

  // The younger producer in memory wins over writeback
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      matchM[i] = memInfo.valid && memInfo.regWrite && (memInfo.rd == exeSrc[i]);
      matchW[i] = wbInfo.valid && wbInfo.regWrite && (wbInfo.rd == exeSrc[i]);
      if (matchM[i]) begin
        fwdSel[i] = 2'd2;
      end else if (matchW[i]) begin
        fwdSel[i] = 2'd1;
      end else begin
        fwdSel[i] = 2'd0;
      end
    end
  end

  assign hz.forwardA = fwdSel[0];
  assign hz.forwardB = fwdSel[1];
  assign hz.forwardC = fwdSel[2];

  // Only registers the decoding instruction reads can cause a stall
  assign matchD = decRegs.useMask & {(decRegs.ra == exeInfo.rd),
                                     (decRegs.rm == exeInfo.rd),
                                     (decRegs.rn == exeInfo.rd)};

  // Loaded data exists only after the memory stage, so the consumer waits one cycle
  assign ldrStall = exeInfo.valid && exeInfo.memToReg && (|matchD);

  assign hz.stallF = ldrStall;
  assign hz.stallD = ldrStall;
  assign hz.flushE = ldrStall | branchTaken;  // Bubble into execute
  assign hz.flushD = branchTaken;             // Drop the word behind the branch

endmodule

//--- hdl/memoryStage.sv
`include "core_defines.svh"

module memoryStage (
  input  logic               clk,
  input  logic               arstN,
  input  core_pkg::exeToMemS fromExe,
  output core_pkg::memToWbS  toWb
);

  logic [`CORE_XLEN-1:0]    dataRam [`CORE_DMEM_DEPTH];
  logic [`CORE_DMEM_AW-1:0] ramAddr;
  logic [`CORE_XLEN-1:0]    loadData;

  assign ramAddr  = fromExe.result[`CORE_DMEM_AW-1:0];  // Upper address bits wrap
  assign loadData = dataRam[ramAddr];                   // Asynchronous read port

  // Every program starts from an all zero data image after reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `CORE_DMEM_DEPTH; i++) begin
        dataRam[i] <= '0;
      end
    end else if (fromExe.valid && fromExe.memWrite) begin
      dataRam[ramAddr] <= fromExe.storeData;
    end
  end

  // Memory to writeback register, this is also the retire record
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      toWb <= '0;
    end else begin
      toWb.valid    <= fromExe.valid;
      toWb.rd       <= fromExe.rd;
      toWb.value    <= fromExe.memToReg ? loadData : fromExe.result;
      toWb.regWrite <= fromExe.regWrite;
    end
  end

endmodule

//--- hdl/pipeCore.sv
`include "core_defines.svh"

module pipeCore (
  input  logic                 clk,
  input  logic                 arstN,
  output logic [`CORE_PCW-1:0] pcF,
  input  core_pkg::instrU      instrF,
  output core_pkg::memToWbS    retire
);

  core_pkg::hazardCtrlS  hz;
  core_pkg::fetchToDecS  fetchToDec;
  core_pkg::decToExeS    decToExe;
  core_pkg::exeToMemS    exeToMem;
  core_pkg::decRegsS     decRegs;
  logic [`CORE_REGW-1:0] regAddrA;
  logic [`CORE_REGW-1:0] regAddrB;
  logic [`CORE_REGW-1:0] regAddrC;
  logic [`CORE_XLEN-1:0] regDataA;
  logic [`CORE_XLEN-1:0] regDataB;
  logic [`CORE_XLEN-1:0] regDataC;
  logic                  branchTaken;
  logic [`CORE_PCW-1:0]  branchTarget;

  fetchStage fetchStage_i (
    .clk          (clk),
    .arstN        (arstN),
    .hz           (hz),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .instrF       (instrF),
    .pcF          (pcF),
    .toDec        (fetchToDec)
  );

  decodeStage decodeStage_i (
    .clk       (clk),
    .arstN     (arstN),
    .hz        (hz),
    .fromFetch (fetchToDec),
    .regAddrA  (regAddrA),
    .regAddrB  (regAddrB),
    .regAddrC  (regAddrC),
    .regDataA  (regDataA),
    .regDataB  (regDataB),
    .regDataC  (regDataC),
    .decRegs   (decRegs),
    .toExe     (decToExe)
  );

  // Writeback port is the retire record itself
  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (regAddrA),
    .rdAddrB (regAddrB),
    .rdAddrC (regAddrC),
    .rdDataA (regDataA),
    .rdDataB (regDataB),
    .rdDataC (regDataC),
    .wb      (retire)
  );

  executeStage executeStage_i (
    .clk          (clk),
    .arstN        (arstN),
    .hz           (hz),
    .fromDec      (decToExe),
    .memFwd       (exeToMem),
    .wbFwd        (retire),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .toMem        (exeToMem)
  );

  memoryStage memoryStage_i (
    .clk     (clk),
    .arstN   (arstN),
    .fromExe (exeToMem),
    .toWb    (retire)
  );

  hazardUnit hazardUnit_i (
    .decRegs     (decRegs),
    .exeInfo     (decToExe),
    .branchTaken (branchTaken),
    .memInfo     (exeToMem),
    .wbInfo      (retire),
    .hz          (hz)
  );

endmodule

//--- hdl/regFile.sv
`include "core_defines.svh"

module regFile (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [`CORE_REGW-1:0] rdAddrA,
  input  logic [`CORE_REGW-1:0] rdAddrB,
  input  logic [`CORE_REGW-1:0] rdAddrC,
  output logic [`CORE_XLEN-1:0] rdDataA,
  output logic [`CORE_XLEN-1:0] rdDataB,
  output logic [`CORE_XLEN-1:0] rdDataC,
  input  core_pkg::memToWbS     wb
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREG];  // Architectural state
  logic                  wbEn;

  assign wbEn = wb.valid && wb.regWrite;

  // Write happens at the edge that closes the writeback cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `CORE_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // Reads see the value being written this cycle
  assign rdDataA = (wbEn && (wb.rd == rdAddrA)) ? wb.value : regs[rdAddrA];
  assign rdDataB = (wbEn && (wb.rd == rdAddrB)) ? wb.value : regs[rdAddrB];
  assign rdDataC = (wbEn && (wb.rd == rdAddrC)) ? wb.value : regs[rdAddrC];

endmodule
